/* hdl/core_pkg.sv */
// widths, reset vector, opcodes, alu codes and pipeline stage structs
package core_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [63:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;

    localparam addr_t RESET_PC = 64'h8000_0000;
    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;

    // if -> id
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // id_ex register content
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     imm;
        reg_addr_t rd;
        logic      reg_wen;
        alu_op_t   alu_op;
        logic      is_jal;
        logic      is_branch;
        logic      branch_ne;
    } decode_pkt_t;

    // ex_wb register content, also the register file write port
    typedef struct packed {
        logic      valid;
        addr_t     pc;
        reg_addr_t rd;
        logic      reg_wen;
        xlen_t     data;
    } retire_t;

    // taken jump or branch from execute
    typedef struct packed {
        logic  en;
        addr_t target;
    } redirect_t;

endpackage

/* hdl/fetch_stage.sv */
// program counter, outstanding fetch request and redirect handling
module fetch_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  core_pkg::redirect_t  redirect_i,
    input  core_pkg::inst_t      if_inst_i,
    output core_pkg::addr_t      if_inst_addr_o,
    output logic                 if_ren_o,
    output core_pkg::fetch_pkt_t fetch_o
);
    import core_pkg::*;

    addr_t pc_q;
    logic  ren_q;

    // request presented last cycle, its instruction arrives this cycle
    logic  req_valid_q;
    addr_t req_pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q        <= RESET_PC;
            ren_q       <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            ren_q <= 1'b1;
            // a redirect kills the request going out this cycle
            req_valid_q <= ren_q & ~redirect_i.en;
            if (redirect_i.en) begin
                pc_q <= redirect_i.target;
            end else if (ren_q) begin
                pc_q <= pc_q + 64'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        req_pc_q <= pc_q;
    end

    assign if_inst_addr_o = pc_q;
    assign if_ren_o       = ren_q;

    // pair the returning word with the pc that asked for it
    always_comb begin
        fetch_o.valid = req_valid_q;
        fetch_o.pc    = req_pc_q;
        fetch_o.inst  = if_inst_i;
    end

endmodule

/* hdl/regs.sv */
// 32-entry integer register file, x0 reads zero, write-through reads
module regs (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::xlen_t     rs1_data_o,
    output core_pkg::xlen_t     rs2_data_o,
    input  core_pkg::retire_t   wb_i
);
    import core_pkg::*;

    xlen_t regs_q [1:31];
    logic  wen;

    assign wen = wb_i.valid && wb_i.reg_wen && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle write to the read index is passed straight through
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wen && (wb_i.rd == addr)) begin
            val = wb_i.data;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

/* hdl/decode_stage.sv */
// instruction decode, immediates, operand forwarding and the id_ex register
module decode_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  core_pkg::fetch_pkt_t  fetch_i,
    input  core_pkg::xlen_t       ex_result_i,
    input  core_pkg::retire_t     wb_i,
    output core_pkg::reg_addr_t   rs1_addr_o,
    output core_pkg::reg_addr_t   rs2_addr_o,
    input  core_pkg::xlen_t       rs1_data_i,
    input  core_pkg::xlen_t       rs2_data_i,
    output core_pkg::decode_pkt_t decode_o
);
    import core_pkg::*;

    inst_t       inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       imm_b;
    xlen_t       rs1_val;
    xlen_t       rs2_val;
    decode_pkt_t decode_d;
    decode_pkt_t decode_q;

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // the instruction in execute wins over the one in writeback
    function automatic xlen_t pick_operand(input reg_addr_t idx, input xlen_t rf_data);
        xlen_t val;
        if ((idx != '0) && decode_q.valid && decode_q.reg_wen && (decode_q.rd == idx)) begin
            val = ex_result_i;
        end else if ((idx != '0) && wb_i.valid && wb_i.reg_wen && (wb_i.rd == idx)) begin
            val = wb_i.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = pick_operand(rs1, rs1_data_i);
        rs2_val = pick_operand(rs2, rs2_data_i);
    end

    always_comb begin
        decode_d        = '0;
        decode_d.pc     = fetch_i.pc;
        decode_d.rd     = rd;
        decode_d.op1    = rs1_val;
        decode_d.op2    = rs2_val;
        decode_d.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                decode_d.valid   = 1'b1;
                decode_d.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: decode_d.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: decode_d.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: decode_d.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: decode_d.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: decode_d.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: decode_d.alu_op = ALU_SLT;
                    default: decode_d.valid = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                decode_d.valid   = 1'b1;
                decode_d.reg_wen = 1'b1;
                decode_d.imm     = imm_i;
                decode_d.op2     = imm_i;
                case (funct3)
                    3'b000: decode_d.alu_op = ALU_ADD;
                    3'b111: decode_d.alu_op = ALU_AND;
                    3'b110: decode_d.alu_op = ALU_OR;
                    3'b100: decode_d.alu_op = ALU_XOR;
                    default: decode_d.valid = 1'b0;
                endcase
            end
            OPC_LUI: begin
                // zero plus the upper immediate
                decode_d.valid   = 1'b1;
                decode_d.reg_wen = 1'b1;
                decode_d.imm     = imm_u;
                decode_d.op1     = '0;
                decode_d.op2     = imm_u;
            end
            OPC_JAL: begin
                decode_d.valid   = 1'b1;
                decode_d.reg_wen = 1'b1;
                decode_d.imm     = imm_j;
                decode_d.is_jal  = 1'b1;
            end
            OPC_BRANCH: begin
                // beq and bne only
                decode_d.valid     = (funct3[2:1] == 2'b00);
                decode_d.imm       = imm_b;
                decode_d.is_branch = 1'b1;
                decode_d.branch_ne = funct3[0];
            end
            default: begin
                decode_d.valid = 1'b0;
            end
        endcase
        if (!fetch_i.valid || flush_i) begin
            decode_d.valid = 1'b0;
        end
    end

    // id_ex register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            decode_q.valid <= 1'b0;
        end else begin
            decode_q <= decode_d;
        end
    end

    assign decode_o = decode_q;

endmodule

/* hdl/execute_stage.sv */
// alu, branch and jump resolution, and the ex_wb retire register
module execute_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  core_pkg::decode_pkt_t decode_i,
    output core_pkg::xlen_t       ex_result_o,
    output core_pkg::redirect_t   redirect_o,
    output logic                  flush_o,
    output core_pkg::retire_t     retire_o
);
    import core_pkg::*;

    xlen_t   alu_result;
    xlen_t   ex_result;
    addr_t   pc_plus4;
    logic    ops_equal;
    logic    branch_taken;
    retire_t retire_d;
    retire_t retire_q;

    always_comb begin
        case (decode_i.alu_op)
            ALU_ADD: alu_result = decode_i.op1 + decode_i.op2;
            ALU_SUB: alu_result = decode_i.op1 - decode_i.op2;
            ALU_AND: alu_result = decode_i.op1 & decode_i.op2;
            ALU_OR:  alu_result = decode_i.op1 | decode_i.op2;
            ALU_XOR: alu_result = decode_i.op1 ^ decode_i.op2;
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}},
                              ($signed(decode_i.op1) < $signed(decode_i.op2))};
            end
            default: alu_result = decode_i.op1 + decode_i.op2;
        endcase
    end

    assign pc_plus4 = decode_i.pc + 64'd4;

    // link value for jal
    assign ex_result   = decode_i.is_jal ? pc_plus4 : alu_result;
    assign ex_result_o = ex_result;

    assign ops_equal    = (decode_i.op1 == decode_i.op2);
    assign branch_taken = decode_i.is_branch & (decode_i.branch_ne ? ~ops_equal : ops_equal);

    // jal always redirects, branches only when taken
    always_comb begin
        redirect_o.en     = decode_i.valid & (decode_i.is_jal | branch_taken);
        redirect_o.target = decode_i.pc + decode_i.imm;
    end

    assign flush_o = redirect_o.en;

    always_comb begin
        retire_d.valid   = decode_i.valid;
        retire_d.pc      = decode_i.pc;
        retire_d.rd      = decode_i.rd;
        retire_d.reg_wen = decode_i.reg_wen;
        retire_d.data    = ex_result;
    end

    // ex_wb register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_q.valid <= 1'b0;
        end else begin
            retire_q <= retire_d;
        end
    end

    assign retire_o = retire_q;

endmodule

/* hdl/core.sv */
// top level of the integer pipeline: fetch, decode, execute, writeback
module core (
    input  logic              clk,
    input  logic              reset_i,
    input  core_pkg::inst_t   if_inst_i,
    output core_pkg::addr_t   if_inst_addr_o,
    output logic              if_ren_o,
    output core_pkg::retire_t retire_o
);
    import core_pkg::*;

    // if -> id
    fetch_pkt_t  fetch;
    // id -> regs
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    // id_ex -> ex
    decode_pkt_t id_ex;
    // ex -> id and if
    xlen_t       ex_result;
    redirect_t   redirect;
    logic        flush;

    fetch_stage fetch_stage_inst (
        .clk            ( clk            ),
        .reset_i        ( reset_i        ),
        .redirect_i     ( redirect       ),
        .if_inst_i      ( if_inst_i      ),
        .if_inst_addr_o ( if_inst_addr_o ),
        .if_ren_o       ( if_ren_o       ),
        .fetch_o        ( fetch          )
    );

    // retire output doubles as the write port
    regs regs_inst (
        .clk        ( clk      ),
        .reset_i    ( reset_i  ),
        .rs1_addr_i ( rs1_addr ),
        .rs2_addr_i ( rs2_addr ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data ),
        .wb_i       ( retire_o )
    );

    decode_stage decode_stage_inst (
        .clk         ( clk       ),
        .reset_i     ( reset_i   ),
        .flush_i     ( flush     ),
        .fetch_i     ( fetch     ),
        .ex_result_i ( ex_result ),
        .wb_i        ( retire_o  ),
        .rs1_addr_o  ( rs1_addr  ),
        .rs2_addr_o  ( rs2_addr  ),
        .rs1_data_i  ( rs1_data  ),
        .rs2_data_i  ( rs2_data  ),
        .decode_o    ( id_ex     )
    );

    execute_stage execute_stage_inst (
        .clk         ( clk       ),
        .reset_i     ( reset_i   ),
        .decode_i    ( id_ex     ),
        .ex_result_o ( ex_result ),
        .redirect_o  ( redirect  ),
        .flush_o     ( flush     ),
        .retire_o    ( retire_o  )
    );

endmodule

/* bench/core_tb.sv */
// testbench for the integer pipeline: clock, reset, instruction rom model, retire checks
module core_tb;
    import core_pkg::*;

    localparam int          ROM_DEPTH      = 32;
    localparam int          TIMEOUT_CYCLES = 50;
    localparam logic [31:0] SEED           = 32'h78a2;

    // expected retire entry
    // rd and data checks are skipped where they carry no meaning
    typedef struct packed {
        addr_t     pc;
        reg_addr_t rd;
        xlen_t     data;
        logic      wen;
        logic      chk_rd;
        logic      chk_data;
    } exp_entry_t;

    logic    clk;
    logic    reset_i;
    inst_t   if_inst_i;
    addr_t   if_inst_addr_o;
    logic    if_ren_o;
    retire_t retire_o;

    inst_t      rom [ROM_DEPTH];
    exp_entry_t expected [$];
    retire_t    retired [$];
    int         mismatch_count;
    int         other_count;

    core u_core (
        .clk            ( clk            ),
        .reset_i        ( reset_i        ),
        .if_inst_i      ( if_inst_i      ),
        .if_inst_addr_o ( if_inst_addr_o ),
        .if_ren_o       ( if_ren_o       ),
        .retire_o       ( retire_o       )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic inst_t r_type_word(input logic [6:0] funct7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] funct3,
                                          input reg_addr_t rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic inst_t op_imm_word(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] funct3, input reg_addr_t rd);
        return {imm, rs1, funct3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic inst_t jal_word(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic inst_t branch_word(input logic [12:0] imm, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic addr_t pc_of(input int idx);
        return RESET_PC + 64'(4 * idx);
    endfunction

    // nop outside the program
    function automatic inst_t rom_word(input addr_t addr);
        addr_t offset;
        inst_t word;
        offset = addr - RESET_PC;
        word   = NOP_INST;
        if ((offset[1:0] == 2'b00) && ((offset >> 2) < addr_t'(ROM_DEPTH))) begin
            word = rom[offset[6:2]];
        end
        return word;
    endfunction

    task automatic load_program();
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = NOP_INST;
        end
        rom[0]  = op_imm_word(12'd5, 5'd0, 3'b000, 5'd1);
        rom[1]  = op_imm_word(12'h0F0, 5'd0, 3'b110, 5'd2);
        rom[2]  = op_imm_word(12'h03C, 5'd2, 3'b111, 5'd3);
        rom[3]  = op_imm_word(12'hFFF, 5'd1, 3'b100, 5'd4);
        rom[4]  = lui_word(20'h12345, 5'd5);
        rom[5]  = r_type_word(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd6);
        // distances one, two and three on x6 and x7
        rom[6]  = r_type_word(7'b0100000, 5'd1, 5'd6, 3'b000, 5'd7);
        rom[7]  = r_type_word(7'b0000000, 5'd7, 5'd6, 3'b111, 5'd8);
        rom[8]  = r_type_word(7'b0000000, 5'd8, 5'd6, 3'b110, 5'd9);
        rom[9]  = r_type_word(7'b0000000, 5'd9, 5'd7, 3'b100, 5'd10);
        rom[10] = r_type_word(7'b0000000, 5'd1, 5'd4, 3'b010, 5'd11);
        rom[11] = r_type_word(7'b0000000, 5'd4, 5'd1, 3'b010, 5'd12);
        // x1 in execute and in writeback at the same time
        rom[12] = op_imm_word(12'd1, 5'd1, 3'b000, 5'd1);
        rom[13] = op_imm_word(12'd1, 5'd1, 3'b000, 5'd1);
        rom[14] = r_type_word(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd13);
        rom[15] = op_imm_word(12'd99, 5'd0, 3'b000, 5'd0);
        rom[16] = r_type_word(7'b0000000, 5'd5, 5'd0, 3'b000, 5'd14);
        // taken beq skips 18 and 19
        rom[17] = branch_word(13'd12, 5'd8, 5'd2, 3'b000);
        rom[18] = op_imm_word(12'd1, 5'd0, 3'b000, 5'd15);
        rom[19] = op_imm_word(12'd2, 5'd0, 3'b000, 5'd15);
        rom[20] = branch_word(13'd8, 5'd8, 5'd2, 3'b001);
        // jal skips 22 and 23
        rom[21] = jal_word(21'd12, 5'd16);
        rom[22] = op_imm_word(12'd3, 5'd0, 3'b000, 5'd15);
        rom[23] = op_imm_word(12'd4, 5'd0, 3'b000, 5'd15);
        rom[24] = r_type_word(7'b0000000, 5'd0, 5'd16, 3'b000, 5'd17);
        rom[25] = r_type_word(7'b0000000, 5'd14, 5'd15, 3'b000, 5'd18);
    endtask

    task automatic add_expected(input int idx, input reg_addr_t rd, input xlen_t data,
                                input logic wen, input logic chk_rd, input logic chk_data);
        exp_entry_t entry;
        entry.pc       = pc_of(idx);
        entry.rd       = rd;
        entry.data     = data;
        entry.wen      = wen;
        entry.chk_rd   = chk_rd;
        entry.chk_data = chk_data;
        expected.push_back(entry);
    endtask

    task automatic load_expected();
        add_expected(0, 5'd1, 64'd5, 1'b1, 1'b1, 1'b1);
        add_expected(1, 5'd2, 64'hF0, 1'b1, 1'b1, 1'b1);
        add_expected(2, 5'd3, 64'h30, 1'b1, 1'b1, 1'b1);
        add_expected(3, 5'd4, 64'hFFFF_FFFF_FFFF_FFFA, 1'b1, 1'b1, 1'b1);
        add_expected(4, 5'd5, 64'h1234_5000, 1'b1, 1'b1, 1'b1);
        add_expected(5, 5'd6, 64'hF5, 1'b1, 1'b1, 1'b1);
        add_expected(6, 5'd7, 64'hF0, 1'b1, 1'b1, 1'b1);
        add_expected(7, 5'd8, 64'hF0, 1'b1, 1'b1, 1'b1);
        add_expected(8, 5'd9, 64'hF5, 1'b1, 1'b1, 1'b1);
        add_expected(9, 5'd10, 64'h05, 1'b1, 1'b1, 1'b1);
        add_expected(10, 5'd11, 64'd1, 1'b1, 1'b1, 1'b1);
        add_expected(11, 5'd12, 64'd0, 1'b1, 1'b1, 1'b1);
        add_expected(12, 5'd1, 64'd6, 1'b1, 1'b1, 1'b1);
        add_expected(13, 5'd1, 64'd7, 1'b1, 1'b1, 1'b1);
        add_expected(14, 5'd13, 64'd14, 1'b1, 1'b1, 1'b1);
        add_expected(15, 5'd0, 64'd0, 1'b1, 1'b1, 1'b0);
        add_expected(16, 5'd14, 64'h1234_5000, 1'b1, 1'b1, 1'b1);
        // branches write nothing
        add_expected(17, 5'd0, 64'd0, 1'b0, 1'b0, 1'b0);
        add_expected(20, 5'd0, 64'd0, 1'b0, 1'b0, 1'b0);
        add_expected(21, 5'd16, 64'h8000_0058, 1'b1, 1'b1, 1'b1);
        add_expected(24, 5'd17, 64'h8000_0058, 1'b1, 1'b1, 1'b1);
        add_expected(25, 5'd18, 64'h1234_5000, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic check_reset_state();
        assert (retire_o.valid == 1'b0) else begin
            $display("Mismatch at %0t: retire_o.valid = %b, expected 0", $time, retire_o.valid);
            mismatch_count++;
        end
        assert (if_inst_addr_o == RESET_PC) else begin
            $display("Mismatch at %0t: if_inst_addr_o = %h, expected %h",
                     $time, if_inst_addr_o, RESET_PC);
            mismatch_count++;
        end
    endtask

    task automatic check_fetch_enable(input logic exp_ren);
        assert (if_ren_o == exp_ren) else begin
            $display("Mismatch at %0t: if_ren_o = %b, expected %b", $time, if_ren_o, exp_ren);
            mismatch_count++;
        end
    endtask

    task automatic check_retire(input retire_t got, input exp_entry_t exp);
        assert (got.pc == exp.pc) else begin
            $display("Mismatch at %0t: retire_o.pc = %h, expected %h", $time, got.pc, exp.pc);
            mismatch_count++;
        end
        assert (got.reg_wen == exp.wen) else begin
            $display("Mismatch at %0t: retire_o.reg_wen = %b, expected %b",
                     $time, got.reg_wen, exp.wen);
            mismatch_count++;
        end
        if (exp.chk_rd) begin
            assert (got.rd == exp.rd) else begin
                $display("Mismatch at %0t: retire_o.rd = %0d, expected %0d",
                         $time, got.rd, exp.rd);
                mismatch_count++;
            end
        end
        if (exp.chk_data) begin
            assert (got.data == exp.data) else begin
                $display("Mismatch at %0t: retire_o.data = %h, expected %h",
                         $time, got.data, exp.data);
                mismatch_count++;
            end
        end
    endtask

    // instruction memory answers one cycle after the address
    initial begin
        if_inst_i = NOP_INST;
        forever begin
            @(posedge clk);
            if_inst_i <= rom_word(if_inst_addr_o);
        end
    end

    // collect retires mid-cycle
    always @(negedge clk) begin
        if (!reset_i && retire_o.valid) begin
            retired.push_back(retire_o);
        end
    end

    initial begin
        int unsigned idle_cycles;
        int          waited;
        int          exp_idx;
        logic        aborted;
        retire_t     got;

        void'($urandom(SEED));
        mismatch_count = 0;
        other_count    = 0;
        reset_i        = 1'b1;
        load_program();
        load_expected();
        idle_cycles = $urandom % 8;

        // reset held over three rising edges
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_state();
            check_fetch_enable(1'b0);
        end
        @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_reset_state();

        repeat (idle_cycles) @(posedge clk);

        // fetch runs once reset is over
        @(negedge clk);
        check_fetch_enable(1'b1);

        exp_idx = 0;
        aborted = 1'b0;
        while ((exp_idx < expected.size()) && !aborted) begin
            waited = 0;
            while ((retired.size() == 0) && (waited < TIMEOUT_CYCLES)) begin
                @(posedge clk);
                waited++;
            end
            if (retired.size() == 0) begin
                $display("Timeout at %0t: no retire within %0d cycles, waiting for pc %h",
                         $time, TIMEOUT_CYCLES, expected[exp_idx].pc);
                other_count++;
                aborted = 1'b1;
            end else begin
                got = retired.pop_front();
                check_retire(got, expected[exp_idx]);
                exp_idx++;
            end
        end

        $display("retire checks done: %0d mismatches, %0d other errors",
                 mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/regs.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/core.sv
bench/core_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert --top-module core_tb -f filelist.f -o core_tb_sim \
    && ./obj_dir/core_tb_sim | tee /dev/stderr | grep -q "Verification passed" \
    || { echo "simulation run did not pass"; exit 1; }
